//--- src/cap_lsu_pkg.sv
// Shared widths, enums and structs for the capability-checked load/store unit
package cap_lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned XLEN = 32;
  parameter int unsigned BE_W = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////////////

  // Access size, same encoding as the core's data_type
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } data_type_e;

  // Response status, EXC_NONE means the access completed
  typedef enum logic [2:0] {
    EXC_NONE       = 3'd0,
    EXC_TAG        = 3'd1,
    EXC_PERM_LOAD  = 3'd2,
    EXC_PERM_STORE = 3'd3,
    EXC_BOUNDS     = 3'd4,
    EXC_MISALIGNED = 3'd5,
    EXC_BUS_ERR    = 3'd6
  } mem_exc_e;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    WAIT_GNT    = 2'd1,
    WAIT_RVALID = 2'd2,
    EXC_RSP     = 2'd3
  } lsu_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic perm_load;
    logic perm_store;
  } cap_perm_t;

  // Top is exclusive and one bit wider so the full address space fits
  typedef struct packed {
    logic            tag;
    cap_perm_t       perms;
    logic [XLEN-1:0] base;
    logic [XLEN:0]   top;
  } cap_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    data_type_e      dtype;
    logic            sign_ext;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    mem_exc_e        exc;
  } lsu_rsp_t;

  // Memory side request, addr is always word aligned
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

endpackage

//--- src/cap_checker.sv
// Data-side capability check of tag, permissions, bounds and alignment
`timescale 1ns/1ps

module cap_checker
  import cap_lsu_pkg::*;
(
  input  cap_t     cap_i,
  input  lsu_req_t req_i,
  output mem_exc_e exc_o
);

  logic [2:0]    acc_size;
  logic [XLEN:0] end_addr;
  logic          perm_ok;
  logic          below_base;
  logic          above_top;
  logic          misaligned;

  ////////////////////////////////////////////////////////////////////////////
  // Access size and alignment
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.dtype)
      HALF: begin
        acc_size   = 3'd2;
        misaligned = req_i.addr[0];
      end
      BYTE: begin
        acc_size   = 3'd1;
        misaligned = 1'b0;
      end
      // Word, and the unused encoding treated as a word
      default: begin
        acc_size   = 3'd4;
        misaligned = |req_i.addr[1:0];
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Permission and bounds
  ////////////////////////////////////////////////////////////////////////////

  assign perm_ok = req_i.we ? cap_i.perms.perm_store : cap_i.perms.perm_load;

  // 33-bit end address, so an access ending at 2^32 still passes
  assign end_addr   = {1'b0, req_i.addr} + (XLEN+1)'(acc_size);
  assign below_base = req_i.addr < cap_i.base;
  assign above_top  = end_addr > cap_i.top;

  // Priority: tag, permission, bounds, alignment
  always_comb begin
    if (!cap_i.tag) begin
      exc_o = EXC_TAG;
    end else if (!perm_ok) begin
      exc_o = req_i.we ? EXC_PERM_STORE : EXC_PERM_LOAD;
    end else if (below_base || above_top) begin
      exc_o = EXC_BOUNDS;
    end else if (misaligned) begin
      exc_o = EXC_MISALIGNED;
    end else begin
      exc_o = EXC_NONE;
    end
  end

endmodule

//--- src/lsu_align.sv
// Byte enables, store lane placement and load extraction with extension
`timescale 1ns/1ps

module lsu_align
  import cap_lsu_pkg::*;
(
  input  lsu_req_t        req_i,
  input  logic [XLEN-1:0] data_rdata_i,
  output logic [BE_W-1:0] be_o,
  output logic [XLEN-1:0] wdata_o,
  output logic [XLEN-1:0] rdata_o
);

  logic [1:0]      byte_off;
  logic [XLEN-1:0] rdata_shift;

  assign byte_off = req_i.addr[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Store side
  ////////////////////////////////////////////////////////////////////////////

  // Byte enables from size and low address bits
  always_comb begin
    case (req_i.dtype)
      HALF: begin
        be_o = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      BYTE: begin
        be_o = 4'b0001 << byte_off;
      end
      default: begin
        be_o = 4'b1111;
      end
    endcase
  end

  // Replicate narrow data into every lane, the byte enables pick the right one
  always_comb begin
    case (req_i.dtype)
      HALF: begin
        wdata_o = {2{req_i.wdata[15:0]}};
      end
      BYTE: begin
        wdata_o = {4{req_i.wdata[7:0]}};
      end
      default: begin
        wdata_o = req_i.wdata;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load side
  ////////////////////////////////////////////////////////////////////////////

  // Bring the addressed byte or halfword down to bit 0
  assign rdata_shift = data_rdata_i >> {byte_off, 3'b000};

  always_comb begin
    case (req_i.dtype)
      HALF: begin
        rdata_o = {{16{req_i.sign_ext & rdata_shift[15]}}, rdata_shift[15:0]};
      end
      BYTE: begin
        rdata_o = {{24{req_i.sign_ext & rdata_shift[7]}}, rdata_shift[7:0]};
      end
      default: begin
        rdata_o = data_rdata_i;
      end
    endcase
  end

endmodule

//--- src/lsu_ctrl.sv
// Load/store FSM for acceptance, memory handshake and client response
`timescale 1ns/1ps

module lsu_ctrl
  import cap_lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_ni,

  // Client request
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  lsu_req_t        req_i,
  input  cap_t            cap_i,

  // Checker and aligner
  output lsu_req_t        held_req_o,
  output cap_t            held_cap_o,
  input  mem_exc_e        chk_exc_i,
  input  logic [BE_W-1:0] be_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic [XLEN-1:0] rdata_i,

  // Memory port
  output logic            data_req_o,
  output mem_req_t        mem_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic            data_err_i,

  // Client response
  output logic            rsp_valid_o,
  output lsu_rsp_t        rsp_o
);

  lsu_state_e state_q, state_d;
  lsu_req_t   req_q;
  cap_t       cap_q;
  logic       accept;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i & req_ready_o;

  // While idle the checker looks at the incoming access, so the
  // accept edge already knows where to go; afterwards it sees the held copy
  assign held_req_o = (state_q == IDLE) ? req_i : req_q;
  assign held_cap_o = (state_q == IDLE) ? cap_i : cap_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_i;
      cap_q <= cap_i;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word aligned address, lanes come from the aligner
  assign mem_o.addr  = {req_q.addr[XLEN-1:2], 2'b00};
  assign mem_o.we    = req_q.we;
  assign mem_o.be    = be_i;
  assign mem_o.wdata = wdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_o.rdata = '0;
    rsp_o.exc   = EXC_NONE;

    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = (chk_exc_i == EXC_NONE) ? WAIT_GNT : EXC_RSP;
        end
      end
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        // Stores wait here too, rdata stays zero for them
        if (data_rvalid_i) begin
          rsp_valid_o = 1'b1;
          rsp_o.exc   = data_err_i ? EXC_BUS_ERR : EXC_NONE;
          rsp_o.rdata = (data_err_i || req_q.we) ? '0 : rdata_i;
          state_d     = IDLE;
        end
      end
      EXC_RSP: begin
        rsp_valid_o = 1'b1;
        rsp_o.exc   = chk_exc_i;
        state_d     = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // Address phase holds until granted
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(mem_o))
    else $error("memory request changed before grant");

  a_rsp_single : assert property (@(posedge clk) disable iff (!rst_ni)
    rsp_valid_o |=> !rsp_valid_o)
    else $error("response valid held for two cycles");

endmodule

//--- src/cap_lsu_top.sv
// Capability-checked load/store unit, checker, aligner and controller
`timescale 1ns/1ps

module cap_lsu_top
  import cap_lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_ni,

  // Client side
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  lsu_req_t        req_i,
  input  cap_t            cap_i,
  output logic            rsp_valid_o,
  output lsu_rsp_t        rsp_o,

  // Data memory side
  output logic            data_req_o,
  output mem_req_t        mem_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic            data_err_i,
  input  logic [XLEN-1:0] data_rdata_i
);

  lsu_req_t        held_req;
  cap_t            held_cap;
  mem_exc_e        chk_exc;
  logic [BE_W-1:0] be;
  logic [XLEN-1:0] wdata;
  logic [XLEN-1:0] rdata;

  cap_checker u_cap_checker (
    .cap_i ( held_cap ),
    .req_i ( held_req ),
    .exc_o ( chk_exc  )
  );

  lsu_align u_lsu_align (
    .req_i        ( held_req     ),
    .data_rdata_i ( data_rdata_i ),
    .be_o         ( be           ),
    .wdata_o      ( wdata        ),
    .rdata_o      ( rdata        )
  );

  lsu_ctrl u_lsu_ctrl (
    .clk           ( clk           ),
    .rst_ni        ( rst_ni        ),
    .req_valid_i   ( req_valid_i   ),
    .req_ready_o   ( req_ready_o   ),
    .req_i         ( req_i         ),
    .cap_i         ( cap_i         ),
    .held_req_o    ( held_req      ),
    .held_cap_o    ( held_cap      ),
    .chk_exc_i     ( chk_exc       ),
    .be_i          ( be            ),
    .wdata_i       ( wdata         ),
    .rdata_i       ( rdata         ),
    .data_req_o    ( data_req_o    ),
    .mem_o         ( mem_o         ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_err_i    ( data_err_i    ),
    .rsp_valid_o   ( rsp_valid_o   ),
    .rsp_o         ( rsp_o         )
  );

endmodule

//--- verif/tb_mem_model.sv
// Data memory model with random grant and read-valid delays and a bus-error region
`timescale 1ns/1ps

module tb_mem_model
  import cap_lsu_pkg::*;
(
  input  logic            clk,
  input  logic            data_req_i,
  input  mem_req_t        mem_i,
  output logic            data_gnt_o,
  output logic            data_rvalid_o,
  output logic            data_err_o,
  output logic [XLEN-1:0] data_rdata_o
);

  logic [XLEN-1:0] mem [0:255];

  initial begin
    logic [7:0]      idx;
    logic [XLEN-1:0] rsp_data;
    bit              granted;
    bit              gnt_armed;
    bit              rsp_pend;
    bit              rsp_err;
    int unsigned     gnt_wait;
    int unsigned     rsp_wait;

    // Fixed seed for the random delays
    void'($urandom(38));

    // Fill pattern built from the word address
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h0101_0101) ^ 32'h5a3c_0000;
    end

    data_gnt_o    = 1'b0;
    data_rvalid_o = 1'b0;
    data_err_o    = 1'b0;
    data_rdata_o  = '0;
    gnt_armed     = 1'b0;
    rsp_pend      = 1'b0;
    rsp_err       = 1'b0;
    rsp_data      = '0;
    gnt_wait      = 0;
    rsp_wait      = 0;

    forever begin
      // Address phase completes at the coming edge
      @(negedge clk);
      granted = data_req_i && data_gnt_o;
      if (granted) begin
        idx      = mem_i.addr[9:2];
        rsp_err  = (mem_i.addr[31:28] == 4'hf);
        rsp_data = '0;
        if (!rsp_err) begin
          if (mem_i.we) begin
            for (int b = 0; b < BE_W; b++) begin
              if (mem_i.be[b]) begin
                mem[idx][8*b +: 8] = mem_i.wdata[8*b +: 8];
              end
            end
          end else begin
            rsp_data = mem[idx];
          end
        end
        rsp_pend = 1'b1;
        rsp_wait = $urandom_range(1, 0);
      end

      @(posedge clk);
      #1;
      data_gnt_o    = 1'b0;
      data_rvalid_o = 1'b0;
      data_err_o    = 1'b0;
      data_rdata_o  = '0;

      // Read-valid one or two cycles after the grant cycle
      if (rsp_pend) begin
        if (rsp_wait == 0) begin
          data_rvalid_o = 1'b1;
          data_err_o    = rsp_err;
          data_rdata_o  = rsp_data;
          rsp_pend      = 1'b0;
        end else begin
          rsp_wait--;
        end
      end

      // Grant zero to three cycles into the request
      if (data_req_i) begin
        if (!gnt_armed) begin
          gnt_wait  = $urandom_range(3, 0);
          gnt_armed = 1'b1;
        end
        if (gnt_wait == 0) begin
          data_gnt_o = 1'b1;
          gnt_armed  = 1'b0;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

endmodule

//--- verif/tb_cap_lsu.sv
// Testbench for the capability-checked load/store unit, driven from a vector file
`timescale 1ns/1ps

module tb_cap_lsu
  import cap_lsu_pkg::*;
();

  localparam int unsigned MAX_VEC = 64;
  localparam int unsigned COLS    = 12;

  logic            clk;
  logic            rst_ni;
  logic            req_valid;
  logic            req_ready;
  lsu_req_t        req;
  cap_t            cap;
  logic            rsp_valid;
  lsu_rsp_t        rsp;
  logic            data_req;
  mem_req_t        mem_req;
  logic            data_gnt;
  logic            data_rvalid;
  logic            data_err;
  logic [XLEN-1:0] data_rdata;

  logic [35:0] vec_mem [0:MAX_VEC*COLS-1];
  int unsigned num_vec;

  cap_lsu_top DUT (
    .clk           ( clk         ),
    .rst_ni        ( rst_ni      ),
    .req_valid_i   ( req_valid   ),
    .req_ready_o   ( req_ready   ),
    .req_i         ( req         ),
    .cap_i         ( cap         ),
    .rsp_valid_o   ( rsp_valid   ),
    .rsp_o         ( rsp         ),
    .data_req_o    ( data_req    ),
    .mem_o         ( mem_req     ),
    .data_gnt_i    ( data_gnt    ),
    .data_rvalid_i ( data_rvalid ),
    .data_err_i    ( data_err    ),
    .data_rdata_i  ( data_rdata  )
  );

  tb_mem_model u_mem (
    .clk           ( clk         ),
    .data_req_i    ( data_req    ),
    .mem_i         ( mem_req     ),
    .data_gnt_o    ( data_gnt    ),
    .data_rvalid_o ( data_rvalid ),
    .data_err_o    ( data_err    ),
    .data_rdata_o  ( data_rdata  )
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
      $display("Regression failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // Byte lanes an access touches, from its size and offset in the word
  function automatic logic [3:0] lane_mask(input data_type_e dtype, input logic [1:0] off);
    logic [3:0] lanes;
    case (dtype)
      BYTE: begin
        lanes = 4'b0001;
      end
      HALF: begin
        lanes = 4'b0011;
      end
      default: begin
        lanes = 4'b1111;
      end
    endcase
    return lanes << off;
  endfunction

  // One access from the vector table, sent and answered
  task automatic run_vector(input int unsigned v);
    int unsigned base_i;
    string       name;
    logic [31:0] exp_exc;
    logic [31:0] exp_rdata;
    int unsigned lat;
    bit          saw_req;
    bit          got_rsp;
    bit          rejected;

    base_i    = v * COLS;
    name      = $sformatf("vec %02h", vec_mem[base_i][7:0]);
    exp_exc   = vec_mem[base_i+10][31:0];
    exp_rdata = vec_mem[base_i+11][31:0];
    rejected  = (exp_exc != 32'(EXC_NONE)) && (exp_exc != 32'(EXC_BUS_ERR));

    @(posedge clk);
    #1;
    req_valid    = 1'b1;
    req.we       = vec_mem[base_i+1][0];
    req.dtype    = data_type_e'(vec_mem[base_i+2][1:0]);
    req.sign_ext = vec_mem[base_i+3][0];
    req.addr     = vec_mem[base_i+4][31:0];
    req.wdata    = vec_mem[base_i+5][31:0];
    cap.tag      = vec_mem[base_i+6][0];
    cap.perms    = vec_mem[base_i+7][1:0];
    cap.base     = vec_mem[base_i+8][31:0];
    cap.top      = vec_mem[base_i+9][32:0];

    // Previous response is done, so the unit must be ready again
    @(negedge clk);
    check_value({name, " ready"}, 32'd1, 32'(req_ready));
    @(posedge clk);
    #1;
    req_valid = 1'b0;

    lat     = 0;
    saw_req = 1'b0;
    got_rsp = 1'b0;
    while (!got_rsp) begin
      @(negedge clk);
      lat++;
      if (data_req) begin
        saw_req = 1'b1;
        // Word address and lanes of the address phase
        if (!rejected) begin
          check_value({name, " mem addr"}, req.addr & 32'hffff_fffc, mem_req.addr);
          check_value({name, " mem we"}, 32'(req.we), 32'(mem_req.we));
          check_value({name, " mem be"}, 32'(lane_mask(req.dtype, req.addr[1:0])),
                      32'(mem_req.be));
        end
      end
      if (rsp_valid) got_rsp = 1'b1;
    end

    if (rejected && saw_req) begin
      $display("%s: memory request raised for an access the check rejected", name);
      $display("Regression failed");
      $fatal(1, "stopping at first error");
    end
    if (rejected) begin
      check_value({name, " latency"}, 32'd1, 32'(lat));
    end else begin
      check_value({name, " rvalid"}, 32'd1, 32'(data_rvalid));
    end
    check_value({name, " exc"}, exp_exc, 32'(rsp.exc));
    check_value({name, " rdata"}, exp_rdata, rsp.rdata);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    cap       = '0;
    num_vec   = 0;

    for (int i = 0; i < MAX_VEC * COLS; i++) begin
      vec_mem[i] = '0;
    end
    $readmemh("verif/lsu_input.txt", vec_mem);
    // Table ends at the first zero id
    while (num_vec < MAX_VEC && vec_mem[num_vec*COLS] != '0) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      $display("No vectors found in verif/lsu_input.txt");
      $display("Regression failed");
      $fatal(1, "empty stimulus file");
    end

    repeat (8) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    @(negedge clk);
    check_value("reset req_ready", 32'd1, 32'(req_ready));
    check_value("reset data_req", 32'd0, 32'(data_req));
    check_value("reset rsp_valid", 32'd0, 32'(rsp_valid));

    for (int unsigned v = 0; v < num_vec; v++) begin
      run_vector(v);
    end

    repeat (2) @(posedge clk);
    $display("Regression passed");
    $finish;
  end

  // Watchdog of 40 cycles per vector plus the reset phase
  initial begin
    @(posedge clk);
    repeat (num_vec * 40 + 7) @(posedge clk);
    $display("Watchdog timeout after %0d cycles, a response never arrived",
             num_vec * 40 + 8);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verif/lsu_input.txt
// id we dtype(0 W,1 H,2 B) sign addr wdata tag perms(2 ld,1 st) base top exp_exc exp_rdata
// exc: 0 none, 1 tag, 2 perm load, 3 perm store, 4 bounds, 5 misaligned, 6 bus error
01 1 0 0 00000010 deadbeef 1 3 00000000 100000000 0 00000000
02 0 0 0 00000010 00000000 1 3 00000000 100000000 0 deadbeef
03 1 0 0 00000014 12345678 1 3 00000000 100000000 0 00000000
04 0 0 0 00000014 00000000 1 3 00000000 100000000 0 12345678
// Byte lanes
05 1 2 0 00000020 ffffff81 1 3 00000000 100000000 0 00000000
06 1 2 0 00000021 0000007f 1 3 00000000 100000000 0 00000000
07 1 2 0 00000022 000000c3 1 3 00000000 100000000 0 00000000
08 1 2 0 00000023 00000044 1 3 00000000 100000000 0 00000000
09 0 0 0 00000020 00000000 1 3 00000000 100000000 0 44c37f81
0a 0 2 1 00000020 00000000 1 3 00000000 100000000 0 ffffff81
0b 0 2 0 00000020 00000000 1 3 00000000 100000000 0 00000081
0c 0 2 1 00000021 00000000 1 3 00000000 100000000 0 0000007f
0d 0 2 1 00000022 00000000 1 3 00000000 100000000 0 ffffffc3
0e 0 2 0 00000022 00000000 1 3 00000000 100000000 0 000000c3
0f 0 2 1 00000023 00000000 1 3 00000000 100000000 0 00000044
// Halfword lanes, then one byte over a halfword
10 1 1 0 00000030 00008001 1 3 00000000 100000000 0 00000000
11 1 1 0 00000032 abcd7ffe 1 3 00000000 100000000 0 00000000
12 0 1 1 00000030 00000000 1 3 00000000 100000000 0 ffff8001
13 0 1 0 00000030 00000000 1 3 00000000 100000000 0 00008001
14 0 1 1 00000032 00000000 1 3 00000000 100000000 0 00007ffe
15 0 0 0 00000030 00000000 1 3 00000000 100000000 0 7ffe8001
16 1 2 0 00000031 00000055 1 3 00000000 100000000 0 00000000
17 0 0 0 00000030 00000000 1 3 00000000 100000000 0 7ffe5501
// Tag and permission faults
18 0 0 0 00000010 00000000 0 3 00000000 100000000 1 00000000
19 1 0 0 00000010 0badf00d 1 2 00000000 100000000 3 00000000
1a 0 0 0 00000010 00000000 1 1 00000000 100000000 2 00000000
1b 1 0 0 00000010 0badf00d 0 0 00000000 100000000 1 00000000
1c 0 0 0 00000010 00000000 1 3 00000000 100000000 0 deadbeef
// Bounds, capability covers 0x100 up to 0x200
1d 0 2 0 000000ff 00000000 1 3 00000100 000000200 4 00000000
1e 1 0 0 00000100 a5a5a5a5 1 3 00000100 000000200 0 00000000
1f 0 2 0 00000100 00000000 1 3 00000100 000000200 0 000000a5
20 1 0 0 000001fc 0f0f0f0f 1 3 00000100 000000200 0 00000000
21 0 0 0 000001fc 00000000 1 3 00000100 000000200 0 0f0f0f0f
22 0 1 0 000001fe 00000000 1 3 00000100 000000200 0 00000f0f
23 0 2 0 00000200 00000000 1 3 00000100 000000200 4 00000000
24 0 0 0 000001fd 00000000 1 3 00000100 000000200 4 00000000
25 1 1 0 000001ff 00001234 1 3 00000100 000000200 4 00000000
// Misaligned
26 0 1 0 00000031 00000000 1 3 00000000 100000000 5 00000000
27 0 0 0 00000022 00000000 1 3 00000000 100000000 5 00000000
28 1 0 0 00000011 11111111 1 3 00000000 100000000 5 00000000
29 1 1 0 00000033 00002222 1 3 00000000 100000000 5 00000000
// Bus error region, the last one ends exactly at 2^32
2a 1 0 0 f0000000 cafef00d 1 3 00000000 100000000 6 00000000
2b 0 2 1 f0000003 00000000 1 3 00000000 100000000 6 00000000
2c 0 0 0 fffffffc 00000000 1 3 00000000 100000000 6 00000000
2d 0 0 0 00000010 00000000 1 3 00000000 100000000 0 deadbeef

//--- sim.f
src/cap_lsu_pkg.sv
src/cap_checker.sv
src/lsu_align.sv
src/lsu_ctrl.sv
src/cap_lsu_top.sv
verif/tb_mem_model.sv
verif/tb_cap_lsu.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run the LSU regression from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_cap_lsu -o tb_cap_lsu \
  && ./obj_dir/tb_cap_lsu | tee /dev/stderr | grep -q "^Regression passed$" \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }
